// File: compile.f
+incdir+hw
hw/mask_alu_pkg.sv
hw/mask_uop_if.sv
hw/mask_uop_decode.sv
hw/mask_logic_unit.sv
hw/mask_scan_unit.sv
hw/mask_result_stage.sv
hw/mask_alu_top.sv
sim/mask_alu_asserts.sv
sim/mask_alu_tb.sv

// File: Makefile
SRCS := $(filter %.sv,$(shell cat compile.f))

.PHONY: all run clean

all: run

obj_dir/Vmask_alu_tb: compile.f $(SRCS) hw/mask_alu_defines.svh
	verilator --binary --assert -j 0 --top-module mask_alu_tb -Mdir obj_dir -f compile.f

run: obj_dir/Vmask_alu_tb
	./obj_dir/Vmask_alu_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/mask_alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mask_alu_defines.svh"

module mask_alu_tb;

  localparam int N_LOGIC   = 8 * 20;
  localparam int N_SCAN    = 3 * 2 * 11;
  localparam int N_COUNT   = 2 * 32;
  localparam int N_STREAM  = 40;
  localparam int N_ILLEGAL = 24;
  localparam int N_RESET   = 7;
  localparam int N_IDLE    = 2;
  localparam int N_UOPS    = N_LOGIC + N_SCAN + N_COUNT + N_STREAM + N_ILLEGAL + N_RESET
                             + N_IDLE;
  // extra 20 cycles cover reset and drain
  localparam int WATCHDOG_NS = (N_UOPS + 20) * 10;

  typedef struct packed {
    logic                       valid;
    logic [`MASK_TAG_WIDTH-1:0] tag;
    mask_alu_pkg::result_word_u data;
    logic                       vta;
    logic                       vma;
  } expect_t;

  logic                          clk;
  logic                          reset;
  logic                          uop_valid;
  logic [`MASK_TAG_WIDTH-1:0]    uop_tag;
  logic [`MASK_FUNCT3_WIDTH-1:0] funct3;
  logic [`MASK_FUNCT6_WIDTH-1:0] funct6;
  logic [`MASK_VS1_WIDTH-1:0]    vs1_index;
  logic                          vm;
  logic [`MASK_VL_WIDTH-1:0]     vl;
  logic [`MASK_VL_WIDTH-1:0]     vstart;
  logic [`MASK_VLEN-1:0]         vs1_data;
  logic [`MASK_VLEN-1:0]         vs2_data;
  logic [`MASK_VLEN-1:0]         vd_data;
  logic [`MASK_VLEN-1:0]         v0_data;
  logic                          result_valid;
  logic [`MASK_TAG_WIDTH-1:0]    result_tag;
  logic [`MASK_VLEN-1:0]         result_data;
  logic                          ignore_vta;
  logic                          ignore_vma;

  expect_t                    pending_q[$];
  int                         issued = 0;
  int                         checked = 0;
  logic [`MASK_TAG_WIDTH-1:0] next_tag = '0;

  mask_alu_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .uop_valid    (uop_valid),
    .uop_tag      (uop_tag),
    .funct3       (funct3),
    .funct6       (funct6),
    .vs1_index    (vs1_index),
    .vm           (vm),
    .vl           (vl),
    .vstart       (vstart),
    .vs1_data     (vs1_data),
    .vs2_data     (vs2_data),
    .vd_data      (vd_data),
    .v0_data      (v0_data),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data),
    .ignore_vta   (ignore_vta),
    .ignore_vma   (ignore_vma)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // expected outcome of one issue cycle from the ISA rules
  function automatic expect_t reference_result(
    input logic                          rst,
    input logic                          valid,
    input logic [`MASK_FUNCT3_WIDTH-1:0] f3,
    input logic [`MASK_FUNCT6_WIDTH-1:0] f6,
    input logic [`MASK_VS1_WIDTH-1:0]    vs1i,
    input logic                          vmi,
    input logic [`MASK_VL_WIDTH-1:0]     vli,
    input logic [`MASK_VL_WIDTH-1:0]     vsi,
    input logic [`MASK_VLEN-1:0]         a,
    input logic [`MASK_VLEN-1:0]         b,
    input logic [`MASK_VLEN-1:0]         d,
    input logic [`MASK_VLEN-1:0]         m0,
    input logic [`MASK_TAG_WIDTH-1:0]    tagi
  );
    expect_t e;
    logic    hit;
    logic    seen;
    int      count;
    int      first;
    e       = '0;
    e.tag   = tagi;
    seen    = 1'b0;
    count   = 0;
    first   = -1;
    if (!rst && valid && f3 == 3'b010) begin
      if (f6[5:3] == 3'b011) begin
        e.valid = vmi;
        e.vta   = vmi;
        for (int i = 0; i < `MASK_VLEN; i++) begin
          case (f6[2:0])
            3'd0: e.data.mask[i] = b[i] & ~a[i];
            3'd1: e.data.mask[i] = b[i] & a[i];
            3'd2: e.data.mask[i] = b[i] | a[i];
            3'd3: e.data.mask[i] = b[i] ^ a[i];
            3'd4: e.data.mask[i] = b[i] | ~a[i];
            3'd5: e.data.mask[i] = ~(b[i] & a[i]);
            3'd6: e.data.mask[i] = ~(b[i] | a[i]);
            default: e.data.mask[i] = ~(b[i] ^ a[i]);
          endcase
          if (i < 32'(vsi)) e.data.mask[i] = d[i];
        end
      end else if (f6 == 6'b010000 && (vs1i == 5'b10000 || vs1i == 5'b10001)) begin
        e.valid = 1'b1;
        for (int i = 0; i < `MASK_VLEN; i++) begin
          hit = b[i] && i < 32'(vli) && (vmi || m0[i]);
          if (hit) count++;
          if (hit && first < 0) first = i;
        end
        if (vs1i == 5'b10000) e.data.scalar.value = 32'(count);
        else if (first < 0) e.data.mask = '1;
        else e.data.scalar.value = 32'(first);
      end else if (f6 == 6'b010100 && vs1i inside {5'b00001, 5'b00010, 5'b00011}) begin
        e.valid = 1'b1;
        e.vta   = 1'b1;
        e.vma   = 1'b1;
        for (int i = 0; i < `MASK_VLEN; i++) begin
          hit = b[i] && i < 32'(vli) && (vmi || m0[i]);
          case (vs1i)
            5'b00001: e.data.mask[i] = !seen && !hit;
            5'b00011: e.data.mask[i] = !seen;
            default:  e.data.mask[i] = !seen && hit;
          endcase
          if (hit) seen = 1'b1;
          // masked-off body element keeps vd
          if (!vmi && i < 32'(vli) && !m0[i]) e.data.mask[i] = d[i];
        end
      end
    end
    return e;
  endfunction

  function automatic logic [`MASK_VLEN-1:0] rand_word();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  function automatic logic [`MASK_VL_WIDTH-1:0] random_vl();
    return 8'($urandom_range(128, 0));
  endfunction

  // 0 sbf, 1 sif, 2 sof, 3 cpop, 4 first
  function automatic logic [`MASK_VS1_WIDTH-1:0] unary_code(input int k);
    case (k)
      0: return 5'b00001;
      1: return 5'b00011;
      2: return 5'b00010;
      3: return 5'b10000;
      default: return 5'b10001;
    endcase
  endfunction

  function automatic logic [`MASK_FUNCT6_WIDTH-1:0] unary_funct6(input int k);
    return (k < 3) ? 6'b010100 : 6'b010000;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic compare_valid(input logic got, input logic exp);
    if (got !== exp) report_mismatch($sformatf("result_valid %b, expected %b", got, exp));
  endtask

  task automatic compare_flags(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) report_mismatch($sformatf("vta/vma %b, expected %b", got, exp));
  endtask

  task automatic compare_tag(
    input logic [`MASK_TAG_WIDTH-1:0] got,
    input logic [`MASK_TAG_WIDTH-1:0] exp
  );
    if (got !== exp) report_mismatch($sformatf("result_tag %h, expected %h", got, exp));
  endtask

  task automatic compare_word(
    input mask_alu_pkg::result_word_u got,
    input mask_alu_pkg::result_word_u exp
  );
    if (got !== exp) begin
      report_mismatch($sformatf("result_data %h, expected %h", got.mask, exp.mask));
    end
  endtask

  // one issue cycle driven on the falling edge
  task automatic drive_uop(
    input logic                          rst,
    input logic                          valid,
    input logic [`MASK_FUNCT3_WIDTH-1:0] f3,
    input logic [`MASK_FUNCT6_WIDTH-1:0] f6,
    input logic [`MASK_VS1_WIDTH-1:0]    vs1i,
    input logic                          vmi,
    input logic [`MASK_VL_WIDTH-1:0]     vli,
    input logic [`MASK_VL_WIDTH-1:0]     vsi,
    input logic [`MASK_VLEN-1:0]         a,
    input logic [`MASK_VLEN-1:0]         b,
    input logic [`MASK_VLEN-1:0]         d,
    input logic [`MASK_VLEN-1:0]         m0
  );
    reset     = rst;
    uop_valid = valid;
    uop_tag   = next_tag;
    funct3    = f3;
    funct6    = f6;
    vs1_index = vs1i;
    vm        = vmi;
    vl        = vli;
    vstart    = vsi;
    vs1_data  = a;
    vs2_data  = b;
    vd_data   = d;
    v0_data   = m0;
    pending_q.push_back(reference_result(rst, valid, f3, f6, vs1i, vmi, vli, vsi,
                                         a, b, d, m0, next_tag));
    issued++;
    next_tag++;
    @(negedge clk);
  endtask

  task automatic random_legal_uop(input logic rst);
    int                            k;
    logic [`MASK_FUNCT6_WIDTH-1:0] f6;
    logic [`MASK_VS1_WIDTH-1:0]    vs1i;
    logic                          vmi;
    k = $urandom_range(12, 0);
    if (k < 8) begin
      f6   = {3'b011, 3'(k)};
      vs1i = 5'($urandom_range(31, 0));
      vmi  = 1'b1;
    end else begin
      f6   = unary_funct6(k - 8);
      vs1i = unary_code(k - 8);
      vmi  = 1'($urandom_range(1, 0));
    end
    drive_uop(rst, 1'b1, 3'b010, f6, vs1i, vmi, random_vl(), 8'($urandom_range(127, 0)),
              rand_word(), rand_word(), rand_word(), rand_word());
  endtask

  task automatic run_logic_ops();
    for (int op = 0; op < 8; op++) begin
      for (int n = 0; n < 20; n++) begin
        drive_uop(1'b0, 1'b1, 3'b010, {3'b011, 3'(op)}, 5'($urandom_range(31, 0)), 1'b1,
                  random_vl(), 8'($urandom_range(127, 0)),
                  rand_word(), rand_word(), rand_word(), rand_word());
      end
    end
  endtask

  task automatic run_scans();
    for (int k = 0; k < 3; k++) begin
      for (int v = 0; v < 2; v++) begin
        for (int n = 0; n < 10; n++) begin
          drive_uop(1'b0, 1'b1, 3'b010, unary_funct6(k), unary_code(k), 1'(v), random_vl(),
                    '0, rand_word(), rand_word(), rand_word(), rand_word());
        end
        // no set bit in the source
        drive_uop(1'b0, 1'b1, 3'b010, unary_funct6(k), unary_code(k), 1'(v), random_vl(),
                  '0, rand_word(), '0, rand_word(), rand_word());
      end
    end
  endtask

  task automatic run_counts();
    for (int k = 3; k < 5; k++) begin
      for (int n = 0; n < 30; n++) begin
        drive_uop(1'b0, 1'b1, 3'b010, unary_funct6(k), unary_code(k),
                  1'($urandom_range(1, 0)), random_vl(), '0,
                  rand_word(), rand_word(), rand_word(), rand_word());
      end
      for (int v = 0; v < 2; v++) begin
        drive_uop(1'b0, 1'b1, 3'b010, unary_funct6(k), unary_code(k), 1'(v), random_vl(),
                  '0, rand_word(), '0, rand_word(), rand_word());
      end
    end
  endtask

  task automatic run_illegal();
    logic [`MASK_FUNCT3_WIDTH-1:0] f3;
    for (int n = 0; n < 8; n++) begin
      f3 = 3'($urandom_range(7, 0));
      if (f3 == 3'b010) f3 = 3'b110;
      drive_uop(1'b0, 1'b1, f3, 6'b010100, 5'b00001, 1'b1, random_vl(), '0,
                rand_word(), rand_word(), rand_word(), rand_word());
    end
    for (int n = 0; n < 8; n++) begin
      drive_uop(1'b0, 1'b1, 3'b010, 6'($urandom_range(15, 0)), 5'b10000, 1'b1, random_vl(),
                '0, rand_word(), rand_word(), rand_word(), rand_word());
    end
    // mask logicals exist only unmasked
    for (int n = 0; n < 8; n++) begin
      drive_uop(1'b0, 1'b1, 3'b010, {3'b011, 3'(n)}, '0, 1'b0, random_vl(), '0,
                rand_word(), rand_word(), rand_word(), rand_word());
    end
  endtask

  task automatic run_reset_midstream();
    repeat (3) random_legal_uop(1'b0);
    repeat (2) random_legal_uop(1'b1);
    repeat (2) random_legal_uop(1'b0);
  endtask

  initial begin : main
    void'($urandom(83));
    reset     = 1'b1;
    uop_valid = 1'b0;
    uop_tag   = '0;
    funct3    = '0;
    funct6    = '0;
    vs1_index = '0;
    vm        = 1'b1;
    vl        = '0;
    vstart    = '0;
    vs1_data  = '0;
    vs2_data  = '0;
    vd_data   = '0;
    v0_data   = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    run_logic_ops();
    run_scans();
    run_counts();
    repeat (N_STREAM) random_legal_uop(1'b0);
    run_illegal();
    run_reset_midstream();
    repeat (N_IDLE) begin
      drive_uop(1'b0, 1'b0, '0, '0, '0, 1'b1, '0, '0, '0, '0, '0, '0);
    end
    wait (checked == issued);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // pop at the sampling edge and check on the next falling edge
  initial begin : compare_results
    expect_t exp_now;
    logic    have_exp;
    forever begin
      @(posedge clk);
      have_exp = 1'b0;
      if (pending_q.size() > 0) begin
        exp_now  = pending_q.pop_front();
        have_exp = 1'b1;
      end
      @(negedge clk);
      if (have_exp) begin
        compare_valid(result_valid, exp_now.valid);
        compare_flags({ignore_vta, ignore_vma}, {exp_now.vta, exp_now.vma});
        if (exp_now.valid) begin
          compare_tag(result_tag, exp_now.tag);
          compare_word(result_data, exp_now.data);
        end
        checked++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: not every result was checked in time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: sim/mask_alu_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mask_alu_asserts (
  input logic clk,
  input logic reset,
  input logic uop_valid,
  input logic result_valid,
  input logic ignore_vta,
  input logic ignore_vma
);

  valid_known_a: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(result_valid)
  ) else $error("result_valid is unknown");

  // one register stage, so every result has an issue behind it
  valid_from_issue_a: assert property (
    @(posedge clk) disable iff (reset) result_valid |-> $past(uop_valid)
  ) else $error("result_valid without uop_valid one cycle earlier");

  vma_implies_vta_a: assert property (
    @(posedge clk) disable iff (reset) ignore_vma |-> ignore_vta
  ) else $error("ignore_vma set without ignore_vta");

  flags_need_valid_a: assert property (
    @(posedge clk) disable iff (reset) (ignore_vta || ignore_vma) |-> result_valid
  ) else $error("ignore flags set without result_valid");

endmodule

bind mask_alu_top mask_alu_asserts asserts_i (
  .clk          (clk),
  .reset        (reset),
  .uop_valid    (uop_valid),
  .result_valid (result_valid),
  .ignore_vta   (ignore_vta),
  .ignore_vma   (ignore_vma)
);

`default_nettype wire

// File: hw/mask_alu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mask_alu_defines.svh"

module mask_alu_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          uop_valid,
  input  logic [`MASK_TAG_WIDTH-1:0]    uop_tag,
  input  logic [`MASK_FUNCT3_WIDTH-1:0] funct3,
  input  logic [`MASK_FUNCT6_WIDTH-1:0] funct6,
  input  logic [`MASK_VS1_WIDTH-1:0]    vs1_index,
  input  logic                          vm,
  input  logic [`MASK_VL_WIDTH-1:0]     vl,
  input  logic [`MASK_VL_WIDTH-1:0]     vstart,
  input  logic [`MASK_VLEN-1:0]         vs1_data,
  input  logic [`MASK_VLEN-1:0]         vs2_data,
  input  logic [`MASK_VLEN-1:0]         vd_data,
  input  logic [`MASK_VLEN-1:0]         v0_data,
  output logic                          result_valid,
  output logic [`MASK_TAG_WIDTH-1:0]    result_tag,
  output logic [`MASK_VLEN-1:0]         result_data,
  output logic                          ignore_vta,
  output logic                          ignore_vma
);

  logic [`MASK_VLEN-1:0]      logic_result;
  mask_alu_pkg::result_word_u scan_result;

  mask_uop_if #(.op_t(mask_alu_pkg::mask_op_e)) uop_bus ();

  mask_uop_decode decode_i (
    .uop_valid (uop_valid),
    .uop_tag   (uop_tag),
    .funct3    (funct3),
    .funct6    (funct6),
    .vs1_index (vs1_index),
    .vm        (vm),
    .vl        (vl),
    .vstart    (vstart),
    .vs1_data  (vs1_data),
    .vs2_data  (vs2_data),
    .vd_data   (vd_data),
    .v0_data   (v0_data),
    .uop       (uop_bus)
  );

  mask_logic_unit logic_i (
    .uop    (uop_bus),
    .result (logic_result)
  );

  mask_scan_unit scan_i (
    .uop    (uop_bus),
    .result (scan_result)
  );

  // only registered stage in the unit
  mask_result_stage result_i (
    .clk          (clk),
    .reset        (reset),
    .uop          (uop_bus),
    .logic_result (logic_result),
    .scan_result  (scan_result),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data),
    .ignore_vta   (ignore_vta),
    .ignore_vma   (ignore_vma)
  );

endmodule

`default_nettype wire

// File: hw/mask_result_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mask_alu_defines.svh"

module mask_result_stage (
  input  logic                        clk,
  input  logic                        reset,
  mask_uop_if.result                  uop,
  input  logic [`MASK_VLEN-1:0]       logic_result,
  input  mask_alu_pkg::result_word_u  scan_result,
  output logic                        result_valid,
  output logic [`MASK_TAG_WIDTH-1:0]  result_tag,
  output logic [`MASK_VLEN-1:0]       result_data,
  output logic                        ignore_vta,
  output logic                        ignore_vma
);

  logic                  is_logic;
  logic                  is_scan;
  logic [`MASK_VLEN-1:0] data_next;

  always_comb begin
    is_logic  = 1'b0;
    is_scan   = 1'b0;
    // vcpop and vfirst leave the scalar in the low bits
    data_next = scan_result.mask;
    case (uop.op)
      mask_alu_pkg::OP_ANDN, mask_alu_pkg::OP_AND, mask_alu_pkg::OP_OR,
      mask_alu_pkg::OP_XOR, mask_alu_pkg::OP_ORN, mask_alu_pkg::OP_NAND,
      mask_alu_pkg::OP_NOR, mask_alu_pkg::OP_XNOR: begin
        is_logic  = 1'b1;
        data_next = logic_result;
      end
      mask_alu_pkg::OP_SBF, mask_alu_pkg::OP_SIF, mask_alu_pkg::OP_SOF: begin
        is_scan   = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      ignore_vta   <= 1'b0;
      ignore_vma   <= 1'b0;
    end else begin
      result_valid <= uop.valid;
      ignore_vta   <= uop.valid & (is_logic | is_scan);
      ignore_vma   <= uop.valid & is_scan;
    end
  end

  always_ff @(posedge clk) begin
    if (uop.valid) begin
      result_tag  <= uop.tag;
      result_data <= data_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/mask_scan_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mask_alu_defines.svh"

module mask_scan_unit (
  mask_uop_if.scan                    uop,
  output mask_alu_pkg::result_word_u  result
);

  logic [`MASK_VLEN-1:0] src;
  logic [`MASK_VLEN-1:0] sof;
  logic [`MASK_VLEN-1:0] sbf;
  logic [`MASK_VLEN-1:0] sif;
  logic [`MASK_VLEN-1:0] scan_word;
  logic [`MASK_VLEN-1:0] scan_merged;
  logic [`MASK_VLEN-1:0] keep_vd;
  logic [`MASK_XLEN-1:0] count;
  logic [`MASK_XLEN-1:0] first_idx;
  logic                  none_set;

  assign src      = uop.src2;
  assign none_set = ~|src;

  // lowest set bit, then everything below it
  // a zero source falls out as sof=0, sbf=sif=all ones
  assign sof = src & (-src);
  assign sbf = sof - 1;
  assign sif = sof | sbf;

  always_comb begin
    case (uop.op)
      mask_alu_pkg::OP_SBF: begin
        scan_word = sbf;
      end
      mask_alu_pkg::OP_SIF: begin
        scan_word = sif;
      end
      default: begin
        scan_word = sof;
      end
    endcase
  end

  // masked-off body elements keep vd
  assign keep_vd     = {`MASK_VLEN{~uop.vm}} & mask_alu_pkg::below_mask(uop.vl) & ~uop.v0;
  assign scan_merged = (uop.vd & keep_vd) | (scan_word & ~keep_vd);

  always_comb begin
    count     = '0;
    first_idx = '0;
    for (int i = 0; i < `MASK_VLEN; i++) begin
      count = count + {{(`MASK_XLEN-1){1'b0}}, src[i]};
      if (sof[i]) begin
        first_idx = i;
      end
    end
  end

  always_comb begin
    result = '0;
    case (uop.op)
      mask_alu_pkg::OP_SBF, mask_alu_pkg::OP_SIF, mask_alu_pkg::OP_SOF: begin
        result.mask = scan_merged;
      end
      mask_alu_pkg::OP_CPOP: begin
        result.scalar.upper = '0;
        result.scalar.value = count;
      end
      mask_alu_pkg::OP_FIRST: begin
        if (none_set) begin
          // -1 across the whole word
          result.mask = '1;
        end else begin
          result.scalar.upper = '0;
          result.scalar.value = first_idx;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/mask_logic_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mask_alu_defines.svh"

module mask_logic_unit (
  mask_uop_if.logic_unit        uop,
  output logic [`MASK_VLEN-1:0] result
);

  logic [`MASK_VLEN-1:0] raw;
  logic [`MASK_VLEN-1:0] head_mask;

  // vs2 is the left operand throughout
  always_comb begin
    case (uop.op)
      mask_alu_pkg::OP_ANDN: begin
        raw = uop.src2 & ~uop.src1;
      end
      mask_alu_pkg::OP_AND: begin
        raw = uop.src2 & uop.src1;
      end
      mask_alu_pkg::OP_OR: begin
        raw = uop.src2 | uop.src1;
      end
      mask_alu_pkg::OP_XOR: begin
        raw = uop.src2 ^ uop.src1;
      end
      mask_alu_pkg::OP_ORN: begin
        raw = uop.src2 | ~uop.src1;
      end
      mask_alu_pkg::OP_NAND: begin
        raw = ~(uop.src2 & uop.src1);
      end
      mask_alu_pkg::OP_NOR: begin
        raw = ~(uop.src2 | uop.src1);
      end
      mask_alu_pkg::OP_XNOR: begin
        raw = ~(uop.src2 ^ uop.src1);
      end
      default: begin
        raw = '0;
      end
    endcase
  end

  // prestart bits keep the old destination
  assign head_mask = mask_alu_pkg::below_mask(uop.vstart);
  assign result    = (uop.vd & head_mask) | (raw & ~head_mask);

endmodule

`default_nettype wire

// File: hw/mask_uop_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "mask_alu_defines.svh"

module mask_uop_decode (
  input  logic                          uop_valid,
  input  logic [`MASK_TAG_WIDTH-1:0]    uop_tag,
  input  logic [`MASK_FUNCT3_WIDTH-1:0] funct3,
  input  logic [`MASK_FUNCT6_WIDTH-1:0] funct6,
  input  logic [`MASK_VS1_WIDTH-1:0]    vs1_index,
  input  logic                          vm,
  input  logic [`MASK_VL_WIDTH-1:0]     vl,
  input  logic [`MASK_VL_WIDTH-1:0]     vstart,
  input  logic [`MASK_VLEN-1:0]         vs1_data,
  input  logic [`MASK_VLEN-1:0]         vs2_data,
  input  logic [`MASK_VLEN-1:0]         vd_data,
  input  logic [`MASK_VLEN-1:0]         v0_data,
  mask_uop_if.decode                    uop
);

  mask_alu_pkg::mask_op_e op;
  logic                   legal;
  logic                   is_logic;
  logic [`MASK_VLEN-1:0]  tail_mask;
  logic [`MASK_VLEN-1:0]  active_mask;

  always_comb begin
    op       = mask_alu_pkg::OP_AND;
    legal    = 1'b0;
    is_logic = 1'b0;
    if (funct3 == mask_alu_pkg::OPMVV) begin
      case (funct6)
        mask_alu_pkg::VMANDN, mask_alu_pkg::VMAND, mask_alu_pkg::VMOR,
        mask_alu_pkg::VMXOR, mask_alu_pkg::VMORN, mask_alu_pkg::VMNAND,
        mask_alu_pkg::VMNOR, mask_alu_pkg::VMXNOR: begin
          // op index follows funct6 low bits
          op       = mask_alu_pkg::mask_op_e'({1'b0, funct6[2:0]});
          is_logic = 1'b1;
          // mask logicals are unmasked only
          legal    = vm;
        end
        mask_alu_pkg::VWXUNARY0: begin
          case (vs1_index)
            mask_alu_pkg::VCPOP: begin
              op    = mask_alu_pkg::OP_CPOP;
              legal = 1'b1;
            end
            mask_alu_pkg::VFIRST: begin
              op    = mask_alu_pkg::OP_FIRST;
              legal = 1'b1;
            end
            default: ;
          endcase
        end
        mask_alu_pkg::VMUNARY0: begin
          case (vs1_index)
            mask_alu_pkg::VMSBF: begin
              op    = mask_alu_pkg::OP_SBF;
              legal = 1'b1;
            end
            mask_alu_pkg::VMSIF: begin
              op    = mask_alu_pkg::OP_SIF;
              legal = 1'b1;
            end
            mask_alu_pkg::VMSOF: begin
              op    = mask_alu_pkg::OP_SOF;
              legal = 1'b1;
            end
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // body elements, and v0 when masked
  assign tail_mask   = mask_alu_pkg::below_mask(vl);
  assign active_mask = tail_mask & ({`MASK_VLEN{vm}} | v0_data);

  assign uop.valid  = uop_valid & legal;
  assign uop.op     = op;
  assign uop.src1   = vs1_data;
  assign uop.src2   = is_logic ? vs2_data : (vs2_data & active_mask);
  assign uop.vd     = vd_data;
  assign uop.v0     = v0_data;
  assign uop.vstart = vstart;
  assign uop.vl     = vl;
  assign uop.vm     = vm;
  assign uop.tag    = uop_tag;

endmodule

`default_nettype wire

// File: hw/mask_uop_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "mask_alu_defines.svh"

interface mask_uop_if #(
  parameter type op_t = logic [3:0]
);

  logic                         valid;
  op_t                          op;
  logic [`MASK_VLEN-1:0]        src1;
  logic [`MASK_VLEN-1:0]        src2;
  logic [`MASK_VLEN-1:0]        vd;
  logic [`MASK_VLEN-1:0]        v0;
  logic [`MASK_VL_WIDTH-1:0]    vstart;
  logic [`MASK_VL_WIDTH-1:0]    vl;
  logic                         vm;
  logic [`MASK_TAG_WIDTH-1:0]   tag;

  modport decode (
    output valid, op, src1, src2, vd, v0, vstart, vl, vm, tag
  );

  modport logic_unit (
    input op, src1, src2, vd, vstart
  );

  // scans need vl and v0 again for the masked-off merge
  modport scan (
    input op, src2, vd, v0, vm, vl
  );

  modport result (
    input valid, op, tag
  );

endinterface

`default_nettype wire

// File: hw/mask_alu_pkg.sv
`default_nettype none

`include "mask_alu_defines.svh"

package mask_alu_pkg;

  typedef enum logic [`MASK_FUNCT3_WIDTH-1:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } funct3_e;

  typedef enum logic [`MASK_FUNCT6_WIDTH-1:0] {
    VWXUNARY0 = 6'b010000,
    VMUNARY0  = 6'b010100,
    VMANDN    = 6'b011000,
    VMAND     = 6'b011001,
    VMOR      = 6'b011010,
    VMXOR     = 6'b011011,
    VMORN     = 6'b011100,
    VMNAND    = 6'b011101,
    VMNOR     = 6'b011110,
    VMXNOR    = 6'b011111
  } funct6_e;

  // unary sub-opcodes live in the vs1 field
  typedef enum logic [`MASK_VS1_WIDTH-1:0] {
    VMSBF  = 5'b00001,
    VMSOF  = 5'b00010,
    VMSIF  = 5'b00011,
    VCPOP  = 5'b10000,
    VFIRST = 5'b10001
  } vs1_op_e;

  // logical ops first, in funct6[2:0] order
  typedef enum logic [3:0] {
    OP_ANDN,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ORN,
    OP_NAND,
    OP_NOR,
    OP_XNOR,
    OP_SBF,
    OP_SIF,
    OP_SOF,
    OP_CPOP,
    OP_FIRST
  } mask_op_e;

  typedef union packed {
    logic [`MASK_VLEN-1:0] mask;
    struct packed {
      logic [`MASK_VLEN-`MASK_XLEN-1:0] upper;
      logic [`MASK_XLEN-1:0]            value;
    } scalar;
  } result_word_u;

  // ones in every bit position below n
  function automatic logic [`MASK_VLEN-1:0] below_mask(
    input logic [`MASK_VL_WIDTH-1:0] n
  );
    logic [`MASK_VLEN-1:0] m;
    for (int i = 0; i < `MASK_VLEN; i++) begin
      m[i] = (i < 32'(n));
    end
    return m;
  endfunction

endpackage

`default_nettype wire

// File: hw/mask_alu_defines.svh
`ifndef MASK_ALU_DEFINES_SVH
`define MASK_ALU_DEFINES_SVH

// vector register width in bits
`define MASK_VLEN 128

// scalar result width
`define MASK_XLEN 32

// stands in for the reorder-buffer entry
`define MASK_TAG_WIDTH 4

// vl and vstart must hold VLEN itself
`define MASK_VL_WIDTH 8

// instruction fields
`define MASK_FUNCT6_WIDTH 6
`define MASK_FUNCT3_WIDTH 3
`define MASK_VS1_WIDTH 5

`endif
